// File: clksel.f
+incdir+hw
hw/clksel_pkg.sv
hw/clk_sync.sv
hw/nstep_ctl.sv
hw/clk_select.sv
hw/clksel_regs.sv
hw/clksel_top.sv
tb/clksel_chk.sv
tb/clksel_tb.sv

// File: hw/clk_select.sv
// Clock select core
// Synchronized selects steer clkout and the PLL mux select

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module clk_select
   import clksel_pkg::*;
(
   input  logic     sysclk,
   input  logic     divbypclk,
   input  logic     jtag_clock_dr,
   input  logic     rst_n,
   input  sel_ctl_t ctl,
   input  logic     capture_l,
   output logic     clkout,
   output logic     sysclk_sel
);

   // Synchronized selects, one per destination clock
   logic byp_en_sync;
   logic altclk_sync_l;
   logic tck_en_sync;
   logic mult_sel;
   logic mult_sel_sync;

   // JTAG path pieces
   logic nstep_clock_dr;
   logic clock_dr;

   // ------------------------------
   // Select synchronizers
   // ------------------------------

   // Bypass path enable, presets so clkout follows divbypclk out of reset
   clk_sync #(
      .RESET_VAL (1'b1)
   ) u_bypclk_sync (
      .clk   (divbypclk),
      .rst_n (rst_n),
      .d     (ctl.sel[2]),
      .q     (byp_en_sync)
   );

   // Active low mult select presets to its idle level
   // Keeps sysclk_sel low through reset
   clk_sync #(
      .RESET_VAL (1'b1)
   ) u_byp_mult_sel_sync (
      .clk   (divbypclk),
      .rst_n (rst_n),
      .d     (ctl.byp_mult_sel_l),
      .q     (altclk_sync_l)
   );

   // TCK path enable
   clk_sync #(
      .RESET_VAL (1'b0)
   ) u_tck_sync (
      .clk   (jtag_clock_dr),
      .rst_n (rst_n),
      .d     (ctl.sel[1]),
      .q     (tck_en_sync)
   );

   // Either bypass or n-step mode asks for the alternate clock
   assign mult_sel = ctl.bypmode | ctl.nstepsel;

   clk_sync #(
      .RESET_VAL (1'b0)
   ) u_mult_sel_sync (
      .clk   (sysclk),
      .rst_n (rst_n),
      .d     (mult_sel),
      .q     (mult_sel_sync)
   );

   // ------------------------------
   // JTAG capture gate
   // ------------------------------

   // capture_l moves on falling tck so the AND cannot glitch
   assign nstep_clock_dr = jtag_clock_dr & ~capture_l;

   // Test mode passes only the n-step window
   assign clock_dr = ctl.testmode_l ? jtag_clock_dr : nstep_clock_dr;

   // ------------------------------
   // Output gates
   // ------------------------------

   // AND-OR of the two enabled sources
   assign clkout = (byp_en_sync & divbypclk) | (tck_en_sync & clock_dr);

   // Alternate clock on mult select, or on force_alt with a mode bit set
   assign sysclk_sel = ~altclk_sync_l | (~ctl.sel[0] & mult_sel_sync);

endmodule

// File: hw/clk_sync.sv
// Multi-flop synchronizer for one control bit
// Reset value picks clear or preset per instance

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module clk_sync #(
   // Level the chain loads while rst_n is low
   parameter logic RESET_VAL = 1'b0
) (
   input  logic clk,
   input  logic rst_n,
   input  logic d,
   output logic q
);

   // Stage 0 samples the async input, last stage is the clean output
   logic [`CLKSEL_SYNC_STAGES-1:0] sync_ff;

   // ------------------------------
   // Shift chain
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // All stages take the reset level
         sync_ff <= {`CLKSEL_SYNC_STAGES{RESET_VAL}};
      end else begin
         sync_ff <= {sync_ff[`CLKSEL_SYNC_STAGES-2:0], d};
      end
   end

   // Output from the final stage
   assign q = sync_ff[`CLKSEL_SYNC_STAGES-1];

endmodule

// File: hw/clksel_cfg.svh
// Clock-select subsystem configuration
// Register map, bus widths and synchronizer depth

`ifndef CLKSEL_CFG_SVH
`define CLKSEL_CFG_SVH

// ------------------------------
// Wishbone bus widths
// ------------------------------

// Word address width
`define CLKSEL_AW 4

// Data width
`define CLKSEL_DW 32

// ------------------------------
// Register word offsets
// ------------------------------

`define CLKSEL_REG_CTRL 4'd0
`define CLKSEL_REG_NSTEP 4'd1
`define CLKSEL_REG_STAT 4'd2

// ------------------------------
// Misc sizes
// ------------------------------

// N-step pulse count width
`define CLKSEL_NSTEP_W 8

// Flops per synchronizer chain
`define CLKSEL_SYNC_STAGES 2

`endif

// File: hw/clksel_pkg.sv
// Clock-select subsystem types
// Wishbone request and response, select-control bundle

`include "clksel_cfg.svh"

package clksel_pkg;

   // ------------------------------
   // Wishbone classic
   // ------------------------------

   // Master to slave
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`CLKSEL_AW-1:0] adr;
      logic [`CLKSEL_DW-1:0] dat;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic                  ack;
      logic [`CLKSEL_DW-1:0] dat;
   } wb_rsp_t;

   // ------------------------------
   // Select controls
   // ------------------------------

   // Packed so that sel lands in CTRL[2:0] and testmode_l in CTRL[6]
   // sel[0] force_alt, active low
   // sel[1] tck path enable
   // sel[2] bypass path enable
   typedef struct packed {
      logic       testmode_l;
      logic       nstepsel;
      logic       bypmode;
      logic       byp_mult_sel_l;
      logic [2:0] sel;
   } sel_ctl_t;

endpackage

// File: hw/clksel_regs.sv
// Clock-select register block
// Wishbone classic slave for CTRL, NSTEP and STAT

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module clksel_regs
   import clksel_pkg::*;
(
   input  logic                       sysclk,
   input  logic                       rst_n,
   input  wb_req_t                    wb_req,
   output wb_rsp_t                    wb_rsp,
   output sel_ctl_t                   ctl,
   output logic [`CLKSEL_NSTEP_W-1:0] nstep_cnt,
   output logic                       nstep_go,
   input  logic                       done,
   input  logic                       sysclk_sel
);

   // Bypass clock selected, force_alt idle, mult select idle, test mode off
   localparam sel_ctl_t CTRL_RST = '{
      testmode_l     : 1'b1,
      nstepsel       : 1'b0,
      bypmode        : 1'b0,
      byp_mult_sel_l : 1'b1,
      sel            : 3'b101
   };

   logic                  ack_q;
   logic                  req_new;
   logic                  wr_en;
   logic [`CLKSEL_DW-1:0] rd_mux;
   logic [`CLKSEL_DW-1:0] rd_q;
   logic                  done_s;
   logic                  sysclk_sel_s;

   // ------------------------------
   // Status synchronizers
   // ------------------------------

   // done idles high, matching nstep_ctl reset
   clk_sync #(
      .RESET_VAL (1'b1)
   ) u_done_sync (
      .clk   (sysclk),
      .rst_n (rst_n),
      .d     (done),
      .q     (done_s)
   );

   clk_sync #(
      .RESET_VAL (1'b0)
   ) u_sysclk_sel_sync (
      .clk   (sysclk),
      .rst_n (rst_n),
      .d     (sysclk_sel),
      .q     (sysclk_sel_s)
   );

   // ------------------------------
   // Bus decode
   // ------------------------------

   // Strobe not yet acknowledged
   assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;
   assign wr_en   = req_new & wb_req.we;

   // Unmapped offsets read as zero
   always_comb begin
      case (wb_req.adr)
         `CLKSEL_REG_CTRL:  rd_mux = `CLKSEL_DW'(ctl);
         `CLKSEL_REG_NSTEP: rd_mux = `CLKSEL_DW'(nstep_cnt);
         `CLKSEL_REG_STAT:  rd_mux = `CLKSEL_DW'({sysclk_sel_s, done_s});
         default:           rd_mux = '0;
      endcase
   end

   // ------------------------------
   // Registers and handshake
   // ------------------------------

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         ack_q     <= 1'b0;
         ctl       <= CTRL_RST;
         nstep_cnt <= '0;
         nstep_go  <= 1'b0;
      end else begin
         // Single cycle ack, one edge after stb
         ack_q    <= req_new;
         nstep_go <= 1'b0;
         if (wr_en && wb_req.adr == `CLKSEL_REG_CTRL) begin
            ctl <= sel_ctl_t'(wb_req.dat[$bits(sel_ctl_t)-1:0]);
         end
         if (wr_en && wb_req.adr == `CLKSEL_REG_NSTEP) begin
            nstep_cnt <= wb_req.dat[`CLKSEL_NSTEP_W-1:0];
            // Any NSTEP write starts a window
            nstep_go  <= 1'b1;
         end
      end
   end

   // Read data captured with the ack
   always_ff @(posedge sysclk) begin
      if (req_new) begin
         rd_q <= rd_mux;
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rd_q;

endmodule

// File: hw/clksel_top.sv
// Clock-select subsystem top
// Register block, n-step controller and select core

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module clksel_top
   import clksel_pkg::*;
(
   input  logic    sysclk,
   input  logic    divbypclk,
   input  logic    jtag_clock_dr,
   input  logic    rst_n,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp,
   output logic    clkout,
   output logic    sysclk_sel
);

   // Register outputs
   sel_ctl_t                   ctl;
   logic [`CLKSEL_NSTEP_W-1:0] nstep_cnt;
   logic                       nstep_go;

   // N-step window state
   logic                       capture_l;
   logic                       done;

   // ------------------------------
   // Register block
   // ------------------------------

   // Status reads see done and sysclk_sel
   clksel_regs u_regs (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .ctl        (ctl),
      .nstep_cnt  (nstep_cnt),
      .nstep_go   (nstep_go),
      .done       (done),
      .sysclk_sel (sysclk_sel)
   );

   // ------------------------------
   // N-step controller
   // ------------------------------

   nstep_ctl u_nstep (
      .jtag_clock_dr (jtag_clock_dr),
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .nstep_go      (nstep_go),
      .nstep_cnt     (nstep_cnt),
      .capture_l     (capture_l),
      .done          (done)
   );

   // ------------------------------
   // Select core
   // ------------------------------

   clk_select u_select (
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n),
      .ctl           (ctl),
      .capture_l     (capture_l),
      .clkout        (clkout),
      .sysclk_sel    (sysclk_sel)
   );

endmodule

// File: hw/nstep_ctl.sv
// N-step capture-window generator
// Opens capture_l for a programmed number of tck pulses per start request

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module nstep_ctl (
   input  logic                       jtag_clock_dr,
   input  logic                       sysclk,
   input  logic                       rst_n,
   input  logic                       nstep_go,
   input  logic [`CLKSEL_NSTEP_W-1:0] nstep_cnt,
   output logic                       capture_l,
   output logic                       done
);

   logic                       go_tgl;
   logic                       go_sync;
   logic                       go_prev;
   logic                       start;
   logic [`CLKSEL_NSTEP_W-1:0] remain;

   // ------------------------------
   // Request crossing
   // ------------------------------

   // Go pulse becomes a toggle so it survives the slow tck domain
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         go_tgl <= 1'b0;
      end else if (nstep_go) begin
         go_tgl <= ~go_tgl;
      end
   end

   clk_sync #(
      .RESET_VAL (1'b0)
   ) u_go_sync (
      .clk   (jtag_clock_dr),
      .rst_n (rst_n),
      .d     (go_tgl),
      .q     (go_sync)
   );

   // Each toggle seen in tck domain is one start
   assign start = go_sync ^ go_prev;

   // ------------------------------
   // Window counter
   // ------------------------------

   // Runs on falling tck so capture_l only moves while tck is low
   // nstep_cnt is static well before the toggle arrives
   always_ff @(negedge jtag_clock_dr or negedge rst_n) begin
      if (!rst_n) begin
         go_prev   <= 1'b0;
         remain    <= '0;
         capture_l <= 1'b1;
         done      <= 1'b1;
      end else begin
         go_prev <= go_sync;
         if (start) begin
            if (nstep_cnt == '0) begin
               // Zero count, nothing to pass
               capture_l <= 1'b1;
               done      <= 1'b1;
            end else begin
               remain    <= nstep_cnt;
               capture_l <= 1'b0;
               done      <= 1'b0;
            end
         end else if (!capture_l) begin
            // One rising edge went through since the last fall
            remain <= remain - `CLKSEL_NSTEP_W'(1);
            if (remain == `CLKSEL_NSTEP_W'(1)) begin
               capture_l <= 1'b1;
               done      <= 1'b1;
            end
         end
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the clksel testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -j 0 \
   --top-module clksel_tb -f clksel.f -o clksel_sim > build.log 2>&1 \
   && ./obj_dir/clksel_sim > sim.log 2>&1 \
   || { echo "build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi

grep -q "sim passed" sim.log || exit 1
exit 0

// File: tb/clksel_chk.sv
// Clock-select bus and select-output checks
// Bound into the register block

`timescale 1ns/100ps

module clksel_chk (
   input logic sysclk,
   input logic rst_n,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic sysclk_sel
);

   // ------------------------------
   // Bus handshake
   // ------------------------------

   // Ack lasts one cycle only
   ack_single : assert property (@(posedge sysclk) disable iff (!rst_n)
      ack |=> !ack)
      else $error("ack high for two cycles in a row");

   // Ack answers a strobe seen on the previous edge
   ack_after_stb : assert property (@(posedge sysclk) disable iff (!rst_n)
      ack |-> $past(cyc & stb))
      else $error("ack without a preceding strobe");

   // ------------------------------
   // Select output
   // ------------------------------

   // PLL mux stays on the main clock through reset
   sel_low_in_reset : assert property (@(posedge sysclk)
      !rst_n |-> !sysclk_sel)
      else $error("sysclk_sel high during reset");

endmodule

bind clksel_regs clksel_chk clksel_chk_inst (
   .sysclk     (sysclk),
   .rst_n      (rst_n),
   .cyc        (wb_req.cyc),
   .stb        (wb_req.stb),
   .ack        (wb_rsp.ack),
   .sysclk_sel (sysclk_sel)
);

// File: tb/clksel_tb.sv
// Clock-select subsystem testbench
// Bus access, select checks, clkout edge counting and n-step windows

`timescale 1ns/100ps

`include "clksel_cfg.svh"

module clksel_tb
   import clksel_pkg::*;
();

   // Sysclk cycle counts for each kind of wait
   localparam integer SYS_NS   = 40;
   localparam integer RST_CYC  = 5;
   localparam integer BUS_CYC  = 4;
   localparam integer SYNC_CYC = 16;
   localparam integer WIN_CYC  = 32;
   localparam integer N_RAND   = 8;
   localparam integer N_STEP   = 4;
   localparam integer T1_CYC   = 2 * BUS_CYC + WIN_CYC;
   localparam integer T2_CYC   = N_RAND * 2 * BUS_CYC + 2 * BUS_CYC;
   localparam integer T3_CYC   = N_RAND * (BUS_CYC + SYNC_CYC);
   localparam integer T4_CYC   = 3 * (BUS_CYC + SYNC_CYC + WIN_CYC);
   localparam integer T5_CYC   = BUS_CYC + SYNC_CYC + N_STEP * (2 * BUS_CYC + 23 * 4);
   localparam integer ALL_CYC  = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC;

   // Expected behavior of one control word
   typedef struct packed {
      logic sysclk_sel;
      logic byp_on;
      logic tck_on;
   } exp_t;

   logic    sysclk;
   logic    divbypclk;
   logic    jtag_clock_dr;
   logic    rst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   logic    clkout;
   logic    sysclk_sel;

   logic [31:0] lfsr_q;

   // Free-running edge counters
   integer clkout_cnt;
   integer byp_cnt;
   integer tck_cnt;

   // Window request from the stimulus to the comparing process
   event   win_start;
   event   win_done;
   integer win_cyc;
   logic   win_byp;
   logic   win_tck;
   integer win_extra;

   clksel_top clksel_top_inst (
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n),
      .wb_req        (wb_req),
      .wb_rsp        (wb_rsp),
      .clkout        (clkout),
      .sysclk_sel    (sysclk_sel)
   );

   // ------------------------------
   // Clocks and counters
   // ------------------------------

   always #20 sysclk = ~sysclk;
   always #50 divbypclk = ~divbypclk;
   always #80 jtag_clock_dr = ~jtag_clock_dr;

   always @(posedge clkout) clkout_cnt = clkout_cnt + 1;
   always @(posedge divbypclk) byp_cnt = byp_cnt + 1;
   always @(posedge jtag_clock_dr) tck_cnt = tck_cnt + 1;

   // ------------------------------
   // Helpers
   // ------------------------------

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "run stopped on error");
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input integer n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   // Reference model of the select rules
   function automatic exp_t exp_sel(input sel_ctl_t c);
      exp_t e;
      e.byp_on     = c.sel[2];
      // In test mode tck only passes inside an n-step window
      e.tck_on     = c.sel[1] & c.testmode_l;
      e.sysclk_sel = ~c.byp_mult_sel_l | (~c.sel[0] & (c.bypmode | c.nstepsel));
      return e;
   endfunction

   task automatic chk_rsp(input string name, input wb_rsp_t rsp,
                          input logic [`CLKSEL_DW-1:0] exp);
      if (rsp.dat !== exp) begin
         stop_with_error($sformatf("Mismatch %s got %0h exp %0h", name, rsp.dat, exp));
      end
   endtask

   task automatic chk_sel(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Mismatch %s got %0h exp %0h", name, got, exp));
      end
   endtask

   task automatic chk_count(input string name, input integer got, input integer exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Mismatch %s got %0h exp %0h", name, got, exp));
      end
   endtask

   // ------------------------------
   // Bus tasks
   // ------------------------------

   // One classic transfer, waits for ack with a limit
   task automatic bus_cycle(input logic we, input logic [`CLKSEL_AW-1:0] adr,
                            input logic [`CLKSEL_DW-1:0] dat, output wb_rsp_t rsp);
      integer wait_cyc;
      @(negedge sysclk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wait_cyc   = 0;
      @(negedge sysclk);
      while (!wb_rsp.ack && wait_cyc < 16) begin
         @(negedge sysclk);
         wait_cyc++;
      end
      if (!wb_rsp.ack) begin
         stop_with_error("bus transfer got no ack within 16 cycles");
      end else begin
         rsp        = wb_rsp;
         wb_req.cyc = 1'b0;
         wb_req.stb = 1'b0;
         wb_req.we  = 1'b0;
      end
   endtask

   task automatic wb_write(input logic [`CLKSEL_AW-1:0] adr, input logic [`CLKSEL_DW-1:0] dat);
      wb_rsp_t rsp;
      bus_cycle(1'b1, adr, dat, rsp);
   endtask

   task automatic wb_read(input logic [`CLKSEL_AW-1:0] adr, output wb_rsp_t rsp);
      bus_cycle(1'b0, adr, '0, rsp);
   endtask

   // Slowest clock sets the synchronizer wait
   task automatic wait_sync();
      repeat (4) @(posedge jtag_clock_dr);
      @(negedge sysclk);
   endtask

   task automatic count_window(input logic byp, input logic tck, input integer cyc);
      @(negedge sysclk);
      #1;
      win_byp   = byp;
      win_tck   = tck;
      win_extra = 0;
      win_cyc   = cyc;
      -> win_start;
      @(win_done);
   endtask

   // ------------------------------
   // Comparing process
   // ------------------------------

   always begin : compare_proc
      integer c0;
      integer b0;
      integer t0;
      integer expn;
      @(win_start);
      c0 = clkout_cnt;
      b0 = byp_cnt;
      t0 = tck_cnt;
      repeat (win_cyc) @(negedge sysclk);
      #1;
      expn = win_extra;
      if (win_byp) expn = expn + (byp_cnt - b0);
      if (win_tck) expn = expn + (tck_cnt - t0);
      chk_count("clkout edge count", clkout_cnt - c0, expn);
      -> win_done;
   end

   // Watchdog, twice the sum of all waits
   initial begin
      #(ALL_CYC * SYS_NS * 2);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $fatal(1, "watchdog");
   end

   // ------------------------------
   // Stimulus
   // ------------------------------

   initial begin
      wb_rsp_t  rsp;
      sel_ctl_t c;
      exp_t     e;
      integer   n;
      sysclk        = 1'b0;
      divbypclk     = 1'b0;
      jtag_clock_dr = 1'b0;
      rst_n         = 1'b1;
      wb_req        = '0;
      lfsr_q        = 32'hb6;
      clkout_cnt    = 0;
      byp_cnt       = 0;
      tck_cnt       = 0;
      // Reset falls ahead of the first sysclk edge
      #1;
      rst_n = 1'b0;
      repeat (RST_CYC) @(posedge sysclk);
      @(negedge sysclk);
      rst_n = 1'b1;

      // Reset state, bypass clock on clkout
      wb_read(`CLKSEL_REG_CTRL, rsp);
      chk_rsp("CTRL reset", rsp, 32'h4d);
      chk_sel("sysclk_sel", sysclk_sel, 1'b0);
      count_window(1'b1, 1'b0, WIN_CYC);

      // CTRL read back and an unmapped offset
      for (int i = 0; i < N_RAND; i++) begin
         c = sel_ctl_t'(rand_bits(7));
         wb_write(`CLKSEL_REG_CTRL, `CLKSEL_DW'(c));
         wb_read(`CLKSEL_REG_CTRL, rsp);
         chk_rsp("CTRL", rsp, `CLKSEL_DW'(c));
      end
      wb_read(4'd3 + `CLKSEL_AW'(rand_bits(3)), rsp);
      chk_rsp("unmapped", rsp, '0);

      // Random selects against the reference
      for (int i = 0; i < N_RAND; i++) begin
         c            = sel_ctl_t'(rand_bits(7));
         c.testmode_l = 1'b1;
         wb_write(`CLKSEL_REG_CTRL, `CLKSEL_DW'(c));
         wait_sync();
         e = exp_sel(c);
         chk_sel("sysclk_sel", sysclk_sel, e.sysclk_sel);
      end

      // Bypass only, tck only, then neither
      for (int i = 0; i < 3; i++) begin
         c     = '0;
         c.testmode_l     = 1'b1;
         c.byp_mult_sel_l = 1'b1;
         c.sel = (i == 0) ? 3'b101 : ((i == 1) ? 3'b011 : 3'b001);
         wb_write(`CLKSEL_REG_CTRL, `CLKSEL_DW'(c));
         wait_sync();
         e = exp_sel(c);
         count_window(e.byp_on, e.tck_on, WIN_CYC);
      end

      // N-step windows in test mode
      c                = '0;
      c.byp_mult_sel_l = 1'b1;
      c.sel            = 3'b011;
      wb_write(`CLKSEL_REG_CTRL, `CLKSEL_DW'(c));
      wait_sync();
      for (int i = 0; i < N_STEP; i++) begin
         n = integer'(rand_bits(4));
         @(negedge sysclk);
         #1;
         win_byp   = 1'b0;
         win_tck   = 1'b0;
         win_extra = n;
         win_cyc   = (n + 8) * 4;
         -> win_start;
         wb_write(`CLKSEL_REG_NSTEP, `CLKSEL_DW'(n));
         @(win_done);
         wb_read(`CLKSEL_REG_STAT, rsp);
         chk_rsp("STAT", rsp, 32'h1);
      end

      $display("sim passed");
      $finish;
   end

endmodule
